//--- build.f
+incdir+.
lc3b_isa_pkg.sv
lc3b_ctrl_pkg.sv
pipe_stage_if.sv
instruction_fetch.sv
instruction_decode.sv
execution_module.sv
memory_module.sv
writeback_module.sv
cpu_datapath.sv
tb_cpu_datapath.sv

//--- Makefile
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
		--top-module tb_cpu_datapath -f build.f -o sim

run: compile
	./obj_dir/sim | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then exit 1; fi
	@grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- tb_cpu_datapath.sv
`default_nettype none
`timescale 1ns/1ps
`include "lc3b_defs.svh"

module tb_cpu_datapath;

	localparam logic [3:0] opc_br  = 4'b0000;
	localparam logic [3:0] opc_add = 4'b0001;
	localparam logic [3:0] opc_ldb = 4'b0010;
	localparam logic [3:0] opc_stb = 4'b0011;
	localparam logic [3:0] opc_and = 4'b0101;
	localparam logic [3:0] opc_ldr = 4'b0110;
	localparam logic [3:0] opc_str = 4'b0111;
	localparam logic [3:0] opc_not = 4'b1001;
	localparam logic [3:0] opc_jmp = 4'b1100;
	localparam logic [3:0] opc_lea = 4'b1110;

	localparam int budget      = 100; // cycles per program after reset.
	localparam int num_runs    = 6;
	localparam int watchdog_ns = num_runs * (budget + 20) * 8 + 1000;

	logic        clk;
	logic        rst_n;
	logic [15:0] mem_addr1;
	logic [15:0] mem_rdata1;
	logic [15:0] mem_addr2;
	logic        mem_read2;
	logic        mem_write2;
	logic [15:0] mem_wdata2;
	logic [1:0]  mem_byte_enable2;
	logic [15:0] mem_rdata2;

	logic [15:0] imem [256];
	logic [15:0] dmem [256];
	logic [7:0]  ptr; // next free program slot.
	logic [31:0] rng;
	int          checks;
	int          errors;
	logic [15:0] st_addr [$];
	logic [15:0] st_data [$];
	logic [1:0]  st_be [$];

	cpu_datapath UUT (
		.clk              (clk),
		.rst_n            (rst_n),
		.mem_addr1        (mem_addr1),
		.mem_rdata1       (mem_rdata1),
		.mem_addr2        (mem_addr2),
		.mem_read2        (mem_read2),
		.mem_write2       (mem_write2),
		.mem_wdata2       (mem_wdata2),
		.mem_byte_enable2 (mem_byte_enable2),
		.mem_rdata2       (mem_rdata2)
	);

	assign mem_rdata1 = imem[mem_addr1[8:1]];
	assign mem_rdata2 = dmem[mem_addr2[8:1]];

	always #4 clk = ~clk;

	// lanes land at the edge that ends the store's memory cycle.
	always @(posedge clk) begin
		if (mem_write2 && mem_byte_enable2[0])
			dmem[mem_addr2[8:1]][7:0] = mem_wdata2[7:0];
		if (mem_write2 && mem_byte_enable2[1])
			dmem[mem_addr2[8:1]][15:8] = mem_wdata2[15:8];
	end

	initial begin
		#(watchdog_ns);
		$display("watchdog expired after %0d ns, the tests did not finish", watchdog_ns);
		$display("SIMULATION FAILED");
		$finish;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [15:0] sext(input logic [15:0] v, input int bits);
		logic signed [15:0] t;
		t = v << (16 - bits);
		return t >>> (16 - bits);
	endfunction

	// n z p as the isa defines them.
	function automatic logic [2:0] cc_of(input logic [15:0] v);
		if (v[15])
			return 3'b100;
		else if (v == 16'h0000)
			return 3'b010;
		return 3'b001;
	endfunction

	function automatic logic [15:0] byte_at(input logic [15:0] addr);
		logic [15:0] w;
		w = dmem[addr[8:1]];
		return addr[0] ? {8'h00, w[15:8]} : {8'h00, w[7:0]};
	endfunction

	function automatic logic [15:0] enc(input logic [3:0] op, input logic [2:0] f1,
			input logic [2:0] f2, input logic [5:0] low);
		return {op, f1, f2, low};
	endfunction

	task automatic rand_word(output logic [15:0] w);
		rng = xorshift32(rng);
		w = rng[15:0];
	endtask

	task automatic emit(input logic [15:0] w);
		imem[ptr] = w;
		ptr = ptr + 8'd1;
	endtask

	task automatic emit_nops(input int n);
		repeat (n) emit(16'h0000);
	endtask

	task automatic check_word(input string what, input logic [15:0] got, input logic [15:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_store(input string what, input int i, input logic [15:0] addr,
			input logic [15:0] data, input logic [1:0] be);
		if (i < st_addr.size()) begin
			check_word($sformatf("%s address", what), st_addr[i], addr);
			check_word($sformatf("%s data", what), st_data[i], data);
			check_word($sformatf("%s lanes", what), {14'h0, st_be[i]}, {14'h0, be});
		end
	endtask

	// holds reset while the next program is written.
	task automatic begin_test();
		@(negedge clk);
		rst_n = 1'b0;
		ptr = 8'd0;
		st_addr.delete();
		st_data.delete();
		st_be.delete();
		for (int i = 0; i < 256; i++) begin
			imem[i[7:0]] = 16'h0000;
			rand_word(dmem[i[7:0]]);
		end
		emit(enc(opc_and, 3'd0, 3'd0, 6'h20)); // r0 = 0, base for all accesses.
		emit_nops(3);
	endtask

	task automatic run_program(input string name, input int n);
		int cyc;
		repeat (16) begin
			@(negedge clk);
			check_word("mem_addr1 in reset", mem_addr1, `LC3B_RESET_PC);
			check_word("strobes in reset", {14'h0, mem_read2, mem_write2}, 16'h0000);
		end
		rst_n = 1'b1;
		check_word("mem_addr1 after reset", mem_addr1, `LC3B_RESET_PC);
		cyc = 0;
		while (st_addr.size() < n && cyc < budget) begin
			@(negedge clk);
			cyc++;
			if (cyc < 3)
				check_word("strobes after reset", {14'h0, mem_read2, mem_write2}, 16'h0000);
			if (mem_write2) begin
				st_addr.push_back(mem_addr2);
				st_data.push_back(mem_wdata2);
				st_be.push_back(mem_byte_enable2);
			end
		end
		checks++;
		assert (st_addr.size() == n) else begin
			errors++;
			$display("%s program stored %0d of %0d words within %0d cycles",
				name, st_addr.size(), n, budget);
		end
	endtask

	task automatic test_alu();
		logic [15:0] a;
		logic [15:0] b;
		logic [4:0]  imm_add;
		logic [4:0]  imm_and;
		begin_test();
		a = dmem[0];
		b = dmem[1];
		imm_add = rng[20:16];
		imm_and = rng[25:21];
		emit(enc(opc_ldr, 3'd1, 3'd0, 6'd0));
		emit(enc(opc_ldr, 3'd2, 3'd0, 6'd1));
		emit_nops(3);
		emit(enc(opc_add, 3'd3, 3'd1, 6'd2));
		emit(enc(opc_add, 3'd4, 3'd1, {1'b1, imm_add}));
		emit(enc(opc_and, 3'd5, 3'd1, 6'd2));
		emit(enc(opc_and, 3'd6, 3'd1, {1'b1, imm_and}));
		emit(enc(opc_not, 3'd7, 3'd1, 6'h3f));
		emit_nops(3);
		for (int r = 3; r < 8; r++)
			emit(enc(opc_str, r[2:0], 3'd0, 6'(r + 13))); // words 16 to 20.
		run_program("alu", 5);
		check_store("add reg", 0, 16'd32, a + b, 2'b11);
		check_store("add imm", 1, 16'd34, a + sext({11'h0, imm_add}, 5), 2'b11);
		check_store("and reg", 2, 16'd36, a & b, 2'b11);
		check_store("and imm", 3, 16'd38, a & sext({11'h0, imm_and}, 5), 2'b11);
		check_store("not", 4, 16'd40, ~a, 2'b11);
	endtask

	task automatic test_loads();
		logic [15:0] w;
		logic [15:0] lo;
		logic [15:0] hi;
		begin_test();
		w = dmem[2];
		lo = byte_at(16'd6);
		hi = byte_at(16'd9);
		emit(enc(opc_ldr, 3'd1, 3'd0, 6'd2));
		emit(enc(opc_ldb, 3'd2, 3'd0, 6'd6)); // even byte.
		emit(enc(opc_ldb, 3'd3, 3'd0, 6'd9));
		emit_nops(3);
		emit(enc(opc_str, 3'd1, 3'd0, 6'd21));
		emit(enc(opc_str, 3'd2, 3'd0, 6'd22));
		emit(enc(opc_str, 3'd3, 3'd0, 6'd23));
		run_program("load", 3);
		check_store("ldr", 0, 16'd42, w, 2'b11);
		check_store("ldb even", 1, 16'd44, lo, 2'b11);
		check_store("ldb odd", 2, 16'd46, hi, 2'b11);
	endtask

	task automatic test_byte_store();
		logic [15:0] v;
		begin_test();
		v = dmem[5];
		emit(enc(opc_ldr, 3'd1, 3'd0, 6'd5));
		emit_nops(3);
		emit(enc(opc_stb, 3'd1, 3'd0, 6'd20));
		emit(enc(opc_stb, 3'd1, 3'd0, 6'd25));
		run_program("stb", 2);
		check_store("stb even", 0, 16'd20, {v[7:0], v[7:0]}, 2'b01);
		check_store("stb odd", 1, 16'd25, {v[7:0], v[7:0]}, 2'b10);
	endtask

	// slot 16 is the fall-through store, slot 17 the branch target.
	task automatic test_branch(input logic [15:0] v, input logic [2:0] nzp);
		logic taken;
		begin_test();
		dmem[6] = v;
		taken = |(cc_of(v) & nzp);
		emit(enc(opc_ldr, 3'd1, 3'd0, 6'd6));
		emit(enc(opc_add, 3'd3, 3'd0, 6'h25)); // marker 5.
		emit(enc(opc_add, 3'd4, 3'd0, 6'h3a)); // marker -6.
		emit_nops(3);
		emit(enc(opc_add, 3'd1, 3'd1, 6'h20));
		emit(enc(opc_br, nzp, 3'd0, 6'd5));
		emit_nops(4);
		emit(enc(opc_str, 3'd4, 3'd0, 6'd24));
		emit(enc(opc_str, 3'd3, 3'd0, 6'd24));
		run_program("branch", 1);
		check_store($sformatf("br nzp=%b", nzp), 0, 16'd48, taken ? 16'h0005 : 16'hfffa, 2'b11);
	endtask

	task automatic test_jmp_lea();
		logic [8:0] off;
		begin_test();
		off = rng[24:16];
		emit(enc(opc_lea, 3'd1, off[8:6], off[5:0]));
		emit(enc(opc_lea, 3'd2, 3'd0, 6'd10)); // jump target, slot 16.
		emit_nops(3);
		emit(enc(opc_jmp, 3'd0, 3'd2, 6'd0));
		emit_nops(4);
		emit(enc(opc_str, 3'd0, 3'd0, 6'd26)); // reached only if jmp falls through.
		emit_nops(1);
		emit(enc(opc_str, 3'd1, 3'd0, 6'd25));
		emit(enc(opc_str, 3'd2, 3'd0, 6'd27));
		run_program("jmp", 2);
		check_store("lea", 0, 16'd50, 16'd10 + (sext({7'h0, off}, 9) << 1), 2'b11);
		check_store("jmp target", 1, 16'd54, 16'd32, 2'b11);
	endtask

	initial begin
		logic [15:0] v;
		clk = 1'b0;
		rst_n = 1'b0;
		rng = 32'h0bdbce3d;
		checks = 0;
		errors = 0;
		ptr = 8'd0;
		for (int i = 0; i < 256; i++) begin
			imem[i[7:0]] = 16'h0000;
			dmem[i[7:0]] = 16'h0000;
		end
		test_alu();
		test_loads();
		test_byte_store();
		rand_word(v);
		test_branch(v, 3'b100); // one of the two is taken.
		test_branch(v, 3'b011);
		test_jmp_lea();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule : tb_cpu_datapath

`default_nettype wire

//--- cpu_datapath.sv
`default_nettype none
`timescale 1ns/1ps

module cpu_datapath (
	input  wire                    clk,
	input  wire                    rst_n,
	output lc3b_isa_pkg::lc3b_word mem_addr1,
	input  lc3b_isa_pkg::lc3b_word mem_rdata1,
	output lc3b_isa_pkg::lc3b_word mem_addr2,
	output logic                   mem_read2,
	output logic                   mem_write2,
	output lc3b_isa_pkg::lc3b_word mem_wdata2,
	output logic [1:0]             mem_byte_enable2,
	input  lc3b_isa_pkg::lc3b_word mem_rdata2
);

	lc3b_isa_pkg::lc3b_word ifid_ir;
	lc3b_isa_pkg::lc3b_word ifid_pc;

	// writeback return path.
	logic                   wb_load;
	lc3b_isa_pkg::lc3b_reg  wb_dest;
	lc3b_isa_pkg::lc3b_word wb_data;
	logic                   branch_taken;
	lc3b_isa_pkg::lc3b_word target;

	pipe_stage_if id_ex ();
	pipe_stage_if ex_mem ();
	pipe_stage_if mem_wb ();

	instruction_fetch if_stage (
		.clk          (clk),
		.rst_n        (rst_n),
		.branch_taken (branch_taken),
		.target       (target),
		.imem_rdata   (mem_rdata1),
		.pc           (mem_addr1),
		.ifid_ir      (ifid_ir),
		.ifid_pc      (ifid_pc)
	);

	instruction_decode id_stage (
		.clk     (clk),
		.rst_n   (rst_n),
		.ir      (ifid_ir),
		.pc      (ifid_pc),
		.wb_load (wb_load),
		.wb_dest (wb_dest),
		.wb_data (wb_data),
		.id_ex   (id_ex.src)
	);

	execution_module ex_stage (
		.clk    (clk),
		.rst_n  (rst_n),
		.id_ex  (id_ex.dst),
		.ex_mem (ex_mem.src)
	);

	memory_module mem_stage (
		.clk              (clk),
		.rst_n            (rst_n),
		.ex_mem           (ex_mem.dst),
		.dmem_rdata       (mem_rdata2),
		.dmem_addr        (mem_addr2),
		.dmem_read        (mem_read2),
		.dmem_write       (mem_write2),
		.dmem_wdata       (mem_wdata2),
		.dmem_byte_enable (mem_byte_enable2),
		.mem_wb           (mem_wb.src)
	);

	writeback_module wb_stage (
		.clk          (clk),
		.rst_n        (rst_n),
		.mem_wb       (mem_wb.dst),
		.wb_load      (wb_load),
		.wb_dest      (wb_dest),
		.wb_data      (wb_data),
		.branch_taken (branch_taken),
		.target       (target)
	);

endmodule : cpu_datapath

`default_nettype wire

//--- writeback_module.sv
`default_nettype none
`timescale 1ns/1ps

module writeback_module (
	input  wire                    clk,
	input  wire                    rst_n,
	pipe_stage_if.dst              mem_wb,
	output logic                   wb_load,
	output lc3b_isa_pkg::lc3b_reg  wb_dest,
	output lc3b_isa_pkg::lc3b_word wb_data,
	output logic                   branch_taken,
	output lc3b_isa_pkg::lc3b_word target
);

	logic [2:0] cc; // n z p.
	logic [2:0] cc_next;
	logic       cond_met;

	always_comb begin
		case (mem_wb.ctrl.regfilemux_sel)
			lc3b_ctrl_pkg::rf_load: wb_data = mem_wb.b;
			default:                wb_data = mem_wb.a; // alu result or lea address.
		endcase
	end

	assign wb_load = mem_wb.ctrl.regfile_load;
	assign wb_dest = mem_wb.ir[11:9];

	always_comb begin
		if (wb_data[15])
			cc_next = 3'b100;
		else if (wb_data == '0)
			cc_next = 3'b010;
		else
			cc_next = 3'b001;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			cc <= 3'b010;
		else if (mem_wb.ctrl.set_cc)
			cc <= cc_next;
	end

	// br tests the codes left by older instructions.
	assign cond_met = |(mem_wb.ir[11:9] & cc);

	assign branch_taken =
		(mem_wb.ctrl.is_branch && mem_wb.ctrl.pcmux_sel == lc3b_ctrl_pkg::pc_branch && cond_met) ||
		(mem_wb.ctrl.pcmux_sel == lc3b_ctrl_pkg::pc_reg);

	assign target = mem_wb.a; // br target or jmp base.

endmodule : writeback_module

`default_nettype wire

//--- memory_module.sv
`default_nettype none
`timescale 1ns/1ps

module memory_module (
	input  wire                    clk,
	input  wire                    rst_n,
	pipe_stage_if.dst              ex_mem,
	input  lc3b_isa_pkg::lc3b_word dmem_rdata,
	output lc3b_isa_pkg::lc3b_word dmem_addr,
	output logic                   dmem_read,
	output logic                   dmem_write,
	output lc3b_isa_pkg::lc3b_word dmem_wdata,
	output logic [1:0]             dmem_byte_enable,
	pipe_stage_if.src              mem_wb
);

	lc3b_isa_pkg::lc3b_word load_data;

	assign dmem_addr  = ex_mem.a;
	assign dmem_read  = ex_mem.ctrl.mem_read;
	assign dmem_write = ex_mem.ctrl.mem_write;

	// stb puts the byte on both lanes, memory takes the enabled one.
	assign dmem_wdata = ex_mem.ctrl.byte_op ? {ex_mem.b[7:0], ex_mem.b[7:0]} : ex_mem.b;

	always_comb begin
		if (!ex_mem.ctrl.mem_write)
			dmem_byte_enable = 2'b00;
		else if (ex_mem.ctrl.byte_op)
			dmem_byte_enable = ex_mem.a[0] ? 2'b10 : 2'b01;
		else
			dmem_byte_enable = 2'b11;
	end

	// ldb zero-extends the addressed byte.
	always_comb begin
		if (ex_mem.ctrl.byte_op)
			load_data = {8'h00, ex_mem.a[0] ? dmem_rdata[15:8] : dmem_rdata[7:0]};
		else
			load_data = dmem_rdata;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			mem_wb.ctrl <= '0;
		else
			mem_wb.ctrl <= ex_mem.ctrl;
	end

	always_ff @(posedge clk) begin
		mem_wb.ir <= ex_mem.ir;
		mem_wb.pc <= ex_mem.pc;
		mem_wb.a  <= ex_mem.a;
		mem_wb.b  <= load_data;
	end

	rw_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
		!(dmem_read && dmem_write));

endmodule : memory_module

`default_nettype wire

//--- execution_module.sv
`default_nettype none
`timescale 1ns/1ps

module execution_module (
	input wire        clk,
	input wire        rst_n,
	pipe_stage_if.dst id_ex,
	pipe_stage_if.src ex_mem
);

	lc3b_isa_pkg::lc3b_word imm5;
	lc3b_isa_pkg::lc3b_word off6;
	lc3b_isa_pkg::lc3b_word off9;
	lc3b_isa_pkg::lc3b_word alu_b;
	lc3b_isa_pkg::lc3b_word alu_out;
	lc3b_isa_pkg::lc3b_word addr;
	logic                   use_addr;

	assign imm5 = {{11{id_ex.ir[4]}}, id_ex.ir[4:0]};
	assign off6 = {{10{id_ex.ir[5]}}, id_ex.ir[5:0]};
	assign off9 = {{7{id_ex.ir[8]}}, id_ex.ir[8:0]};

	assign alu_b = id_ex.ir[5] ? imm5 : id_ex.b;

	always_comb begin
		case (id_ex.ctrl.alu_op)
			lc3b_ctrl_pkg::alu_add: alu_out = id_ex.a + alu_b;
			lc3b_ctrl_pkg::alu_and: alu_out = id_ex.a & alu_b;
			lc3b_ctrl_pkg::alu_not: alu_out = ~id_ex.a;
			default:                alu_out = id_ex.a;
		endcase
	end

	// br and lea are pc relative, byte accesses use an unscaled offset.
	always_comb begin
		if (id_ex.ctrl.is_branch || id_ex.ctrl.regfilemux_sel == lc3b_ctrl_pkg::rf_adder)
			addr = id_ex.pc + {off9[14:0], 1'b0};
		else if (id_ex.ctrl.byte_op)
			addr = id_ex.a + off6;
		else
			addr = id_ex.a + {off6[14:0], 1'b0};
	end

	assign use_addr = id_ex.ctrl.mem_read | id_ex.ctrl.mem_write | id_ex.ctrl.is_branch |
		(id_ex.ctrl.regfilemux_sel == lc3b_ctrl_pkg::rf_adder);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			ex_mem.ctrl <= '0;
		else
			ex_mem.ctrl <= id_ex.ctrl;
	end

	always_ff @(posedge clk) begin
		ex_mem.ir <= id_ex.ir;
		ex_mem.pc <= id_ex.pc;
		ex_mem.a  <= use_addr ? addr : alu_out;
		ex_mem.b  <= id_ex.b; // store data.
	end

	// decode must only flag byte lanes for the byte opcodes.
	byte_op_legal: assert property (@(posedge clk) disable iff (!rst_n)
		id_ex.ctrl.byte_op |->
			(id_ex.ctrl.opcode inside {lc3b_isa_pkg::op_ldb, lc3b_isa_pkg::op_stb}));

endmodule : execution_module

`default_nettype wire

//--- instruction_decode.sv
`default_nettype none
`timescale 1ns/1ps
`include "lc3b_defs.svh"

module instruction_decode (
	input  wire                    clk,
	input  wire                    rst_n,
	input  lc3b_isa_pkg::lc3b_word ir,
	input  lc3b_isa_pkg::lc3b_word pc,
	input  wire                    wb_load,
	input  lc3b_isa_pkg::lc3b_reg  wb_dest,
	input  lc3b_isa_pkg::lc3b_word wb_data,
	pipe_stage_if.src              id_ex
);

	lc3b_isa_pkg::lc3b_opcode   opcode;
	lc3b_ctrl_pkg::lc3b_control ctrl;
	lc3b_isa_pkg::lc3b_reg      sr1;
	lc3b_isa_pkg::lc3b_reg      sr2;
	lc3b_isa_pkg::lc3b_word     sr1_data;
	lc3b_isa_pkg::lc3b_word     sr2_data;
	lc3b_isa_pkg::lc3b_word     regs [`LC3B_NUM_REGS];

	assign opcode = lc3b_isa_pkg::lc3b_opcode'(ir[15:12]);

	always_comb begin
		ctrl = '0;
		case (opcode)
			lc3b_isa_pkg::op_add: begin
				ctrl.opcode       = opcode;
				ctrl.alu_op       = lc3b_ctrl_pkg::alu_add;
				ctrl.regfile_load = 1'b1;
			end
			lc3b_isa_pkg::op_and: begin
				ctrl.opcode       = opcode;
				ctrl.alu_op       = lc3b_ctrl_pkg::alu_and;
				ctrl.regfile_load = 1'b1;
			end
			lc3b_isa_pkg::op_not: begin
				ctrl.opcode       = opcode;
				ctrl.alu_op       = lc3b_ctrl_pkg::alu_not;
				ctrl.regfile_load = 1'b1;
			end
			lc3b_isa_pkg::op_br: begin
				ctrl.opcode    = opcode;
				ctrl.pcmux_sel = lc3b_ctrl_pkg::pc_branch;
				ctrl.is_branch = 1'b1;
			end
			lc3b_isa_pkg::op_jmp: begin
				ctrl.opcode    = opcode;
				ctrl.alu_op    = lc3b_ctrl_pkg::alu_pass;
				ctrl.pcmux_sel = lc3b_ctrl_pkg::pc_reg;
			end
			lc3b_isa_pkg::op_lea: begin
				ctrl.opcode         = opcode;
				ctrl.regfilemux_sel = lc3b_ctrl_pkg::rf_adder;
				ctrl.regfile_load   = 1'b1;
			end
			lc3b_isa_pkg::op_ldr, lc3b_isa_pkg::op_ldb: begin
				ctrl.opcode         = opcode;
				ctrl.regfilemux_sel = lc3b_ctrl_pkg::rf_load;
				ctrl.regfile_load   = 1'b1;
				ctrl.mem_read       = 1'b1;
				ctrl.byte_op        = (opcode == lc3b_isa_pkg::op_ldb);
			end
			lc3b_isa_pkg::op_str, lc3b_isa_pkg::op_stb: begin
				ctrl.opcode    = opcode;
				ctrl.mem_write = 1'b1;
				ctrl.byte_op   = (opcode == lc3b_isa_pkg::op_stb);
			end
			default: ctrl = '0; // unsupported, becomes a nop.
		endcase
		ctrl.set_cc = ctrl.regfile_load;
	end

	// stores read the source register from the dr field.
	assign sr1 = ir[8:6];
	assign sr2 = ctrl.mem_write ? ir[11:9] : ir[2:0];

	// write-first, so the third instruction after a write sees it.
	assign sr1_data = (wb_load && wb_dest == sr1) ? wb_data : regs[sr1];
	assign sr2_data = (wb_load && wb_dest == sr2) ? wb_data : regs[sr2];

	always_ff @(posedge clk) begin
		if (wb_load)
			regs[wb_dest] <= wb_data;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			id_ex.ctrl <= '0;
		else
			id_ex.ctrl <= ctrl;
	end

	always_ff @(posedge clk) begin
		id_ex.ir <= ir;
		id_ex.pc <= pc;
		id_ex.a  <= sr1_data;
		id_ex.b  <= sr2_data;
	end

endmodule : instruction_decode

`default_nettype wire

//--- instruction_fetch.sv
`default_nettype none
`timescale 1ns/1ps
`include "lc3b_defs.svh"

module instruction_fetch (
	input  wire                     clk,
	input  wire                     rst_n,
	input  wire                     branch_taken,
	input  lc3b_isa_pkg::lc3b_word  target,
	input  lc3b_isa_pkg::lc3b_word  imem_rdata,
	output lc3b_isa_pkg::lc3b_word  pc,
	output lc3b_isa_pkg::lc3b_word  ifid_ir,
	output lc3b_isa_pkg::lc3b_word  ifid_pc
);

	lc3b_isa_pkg::lc3b_word pc_plus2;

	assign pc_plus2 = pc + 16'd2;

	// branch and jmp resolve in writeback.
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc      <= `LC3B_RESET_PC;
			ifid_ir <= '0; // br with nzp=000, never taken.
		end else begin
			pc      <= branch_taken ? target : pc_plus2;
			ifid_ir <= imem_rdata;
		end
	end

	always_ff @(posedge clk) begin
		ifid_pc <= pc_plus2;
	end

	// targets come from execute, so an odd one means a bad offset path.
	pc_even: assert property (@(posedge clk) disable iff (!rst_n) pc[0] == 1'b0);

endmodule : instruction_fetch

`default_nettype wire

//--- pipe_stage_if.sv
`default_nettype none
`timescale 1ns/1ps

// one pipeline register, written by the upstream stage every clock.
interface pipe_stage_if;

	lc3b_isa_pkg::lc3b_word    ir;
	lc3b_isa_pkg::lc3b_word    pc; // next sequential pc.
	lc3b_ctrl_pkg::lc3b_control ctrl;
	lc3b_isa_pkg::lc3b_word    a;  // sr1, later alu or address result.
	lc3b_isa_pkg::lc3b_word    b;  // sr2, later store or load data.

	modport src (
		output ir,
		output pc,
		output ctrl,
		output a,
		output b
	);

	modport dst (
		input ir,
		input pc,
		input ctrl,
		input a,
		input b
	);

endinterface : pipe_stage_if

`default_nettype wire

//--- lc3b_ctrl_pkg.sv
`default_nettype none

package lc3b_ctrl_pkg;

	typedef enum logic [1:0] {
		alu_pass = 2'b00,
		alu_add  = 2'b01,
		alu_and  = 2'b10,
		alu_not  = 2'b11
	} alu_op_t;

	typedef enum logic [1:0] {
		pc_seq    = 2'b00,
		pc_branch = 2'b01,
		pc_reg    = 2'b10 // jmp base register.
	} pcmux_sel_t;

	typedef enum logic [1:0] {
		rf_alu   = 2'b00,
		rf_load  = 2'b01,
		rf_adder = 2'b10
	} regfilemux_sel_t;

	// all zero is a nop.
	typedef struct packed {
		lc3b_isa_pkg::lc3b_opcode opcode;
		alu_op_t                  alu_op;
		pcmux_sel_t               pcmux_sel;
		regfilemux_sel_t          regfilemux_sel;
		logic                     regfile_load;
		logic                     mem_read;
		logic                     mem_write;
		logic                     byte_op;
		logic                     set_cc;
		logic                     is_branch;
	} lc3b_control;

endpackage : lc3b_ctrl_pkg

`default_nettype wire

//--- lc3b_isa_pkg.sv
`default_nettype none

package lc3b_isa_pkg;

	// data and address are the same width on lc-3b.
	typedef logic [15:0] lc3b_word;

	typedef logic [2:0] lc3b_reg;

	// architectural encodings, only the implemented subset.
	typedef enum logic [3:0] {
		op_br  = 4'b0000,
		op_add = 4'b0001,
		op_ldb = 4'b0010,
		op_stb = 4'b0011,
		op_and = 4'b0101,
		op_ldr = 4'b0110,
		op_str = 4'b0111,
		op_not = 4'b1001,
		op_jmp = 4'b1100,
		op_lea = 4'b1110
	} lc3b_opcode;

endpackage : lc3b_isa_pkg

`default_nettype wire

//--- lc3b_defs.svh
`ifndef LC3B_DEFS_SVH
`define LC3B_DEFS_SVH

// first fetch address out of reset.
`define LC3B_RESET_PC 16'h0000

// general purpose registers r0..r7.
`define LC3B_NUM_REGS 8

`endif
